// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_dbus_subsys
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== include/dbus_macros.svh ====
`ifndef DBUS_MACROS_SVH
`define DBUS_MACROS_SVH

// bus widths
`define DBUS_DATA_W 32
`define DBUS_ADDR_W 32

// on-chip RAM geometry
`define RAM_WORDS 256
`define RAM_IDX_W 8

// serial transmit path
`define TX_FIFO_DEPTH 8
`define CPLD_WR_CYCLES 2

`endif

// ==== sim/tb_dbus_subsys.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

module tb_dbus_subsys;
    localparam int CLK_PERIOD = 40;
    // 200 us covers about 1500 cycles of tests with margin
    localparam int WATCHDOG_CYCLES = 5000;
    localparam logic [31:0] CPLD_BASE = 32'h1000_0000;

    logic        clk;
    logic        rst_i;
    logic        read_i;
    logic        write_i;
    logic [31:0] address_i;
    logic [3:0]  byteenable_i;
    logic [31:0] wrdata_i;
    logic [31:0] rddata_o;
    logic        stall_o;
    logic        cpld_tready_i;
    logic        cpld_tsre_i;
    logic        cpld_wrn_o;
    logic        cpld_rdn_o;
    logic [7:0]  cpld_data_o;

    logic [31:0] lfsr_q;
    logic [31:0] ram_model [`RAM_WORDS];
    logic [7:0]  idx_list [16];
    logic [7:0]  expect_q [$];
    logic [7:0]  sent_q [$];
    logic        stream_done;

    dbus_subsys_top uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

    // one byte per low pulse on wrn taken at its rising edge
    always begin : cpld_monitor
        time fall_t;
        @(negedge cpld_wrn_o);
        fall_t = $time;
        @(posedge cpld_wrn_o);
        check_value("cpld_wrn_o low time", 32'(`CPLD_WR_CYCLES * CLK_PERIOD),
                    32'($time - fall_t));
        sent_q.push_back(cpld_data_o);
    end

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic logic [31:0] ram_addr(input logic [7:0] idx);
        return {22'd0, idx, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic ensure(input logic cond, input string what);
        assert (cond) else begin
            $display("error at %0t: %s", $time, what);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // holds the request until stall_o is low and counts stalled cycles
    task automatic drive_request(input logic rd, input logic wr, input logic [31:0] addr,
                                 input logic [3:0] be, input logic [31:0] data,
                                 output logic [31:0] rdata, output int stalls);
        @(posedge clk);
        read_i       <= rd;
        write_i      <= wr;
        address_i    <= addr;
        byteenable_i <= be;
        wrdata_i     <= data;
        stalls = 0;
        @(negedge clk);
        while (stall_o) begin
            stalls++;
            @(negedge clk);
        end
        rdata = rddata_o;
        @(posedge clk);
        read_i  <= 1'b0;
        write_i <= 1'b0;
    endtask

    // exp_stalls below zero means the stall count is not checked
    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data, input int exp_stalls);
        logic [31:0] unused_rd;
        int          stalls;
        drive_request(1'b0, 1'b1, addr, be, data, unused_rd, stalls);
        if (exp_stalls >= 0) begin
            check_value("stall_o cycles", exp_stalls, stalls);
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, input logic [31:0] expected,
                            input int exp_stalls);
        logic [31:0] rd;
        int          stalls;
        drive_request(1'b1, 1'b0, addr, 4'hf, 32'd0, rd, stalls);
        check_value("rddata_o", expected, rd);
        if (exp_stalls >= 0) begin
            check_value("stall_o cycles", exp_stalls, stalls);
        end
    endtask

    task automatic push_cpld_byte(input logic [31:0] data, input int exp_stalls);
        expect_q.push_back(data[7:0]);
        bus_write(CPLD_BASE, 4'b0001, data, exp_stalls);
    endtask

    task automatic read_status(input logic full, input logic empty);
        bus_read(CPLD_BASE + 32'd4, {29'd0, cpld_tsre_i, full, empty}, 0);
    endtask

    task automatic compare_sent_bytes();
        logic [7:0] exp_b;
        logic [7:0] got_b;
        while (sent_q.size() < expect_q.size()) begin
            @(negedge clk);
        end
        while (expect_q.size() > 0) begin
            exp_b = expect_q.pop_front();
            got_b = sent_q.pop_front();
            check_value("cpld_data_o", 32'(exp_b), 32'(got_b));
        end
        ensure(sent_q.size() == 0, "more bytes on cpld_data_o than were written");
    endtask

    task automatic reset_state_check();
        check_value("stall_o", 32'd0, 32'(stall_o));
        check_value("cpld_wrn_o", 32'd1, 32'(cpld_wrn_o));
        check_value("cpld_rdn_o", 32'd1, 32'(cpld_rdn_o));
        read_status(1'b0, 1'b1);
    endtask

    task automatic full_word_rw();
        logic [31:0] d;
        int          i;
        for (i = 0; i < 16; i++) begin
            idx_list[i] = 8'(i * 17 + 5);
            d = random_bits(32);
            ram_model[idx_list[i]] = d;
            bus_write(ram_addr(idx_list[i]), 4'hf, d, 0);
        end
        for (i = 0; i < 16; i++) begin
            bus_read(ram_addr(idx_list[i]), ram_model[idx_list[i]], 1);
        end
    endtask

    task automatic partial_write_merge();
        logic [3:0]  be_list [8];
        logic [31:0] d;
        logic [7:0]  idx;
        int          i;
        be_list = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                    4'b0011, 4'b1100, 4'b0110, 4'b1011};
        for (i = 0; i < 24; i++) begin
            idx = idx_list[i % 16];
            d = random_bits(32);
            ram_model[idx] = lane_merge(ram_model[idx], d, be_list[i % 8]);
            bus_write(ram_addr(idx), be_list[i % 8], d, 1);
        end
        for (i = 0; i < 16; i++) begin
            bus_read(ram_addr(idx_list[i]), ram_model[idx_list[i]], 1);
        end
    endtask

    task automatic cpld_stream_order();
        int i;
        for (i = 0; i < 12; i++) begin
            push_cpld_byte(random_bits(8), 0);
        end
        compare_sent_bytes();
        // transmit shift register still busy
        @(posedge clk);
        cpld_tsre_i <= 1'b0;
        @(negedge clk);
        read_status(1'b0, 1'b1);
    endtask

    task automatic fifo_backpressure();
        logic [31:0] stream [16];
        logic [31:0] bit_r;
        int          i;
        @(posedge clk);
        cpld_tready_i <= 1'b0;
        for (i = 0; i < `TX_FIFO_DEPTH; i++) begin
            push_cpld_byte(random_bits(8), 0);
        end
        read_status(1'b1, 1'b0);
        fork
            push_cpld_byte(random_bits(8), -1);
            begin
                repeat (10) @(negedge clk);
                ensure(stall_o === 1'b1, "write to a full FIFO was not stalled");
                check_value("bytes sent while tready low", 32'd0, 32'(sent_q.size()));
                @(posedge clk);
                cpld_tready_i <= 1'b1;
            end
        join
        compare_sent_bytes();

        for (i = 0; i < 16; i++) begin
            stream[i] = random_bits(8);
        end
        stream_done = 1'b0;
        fork
            begin
                for (i = 0; i < 16; i++) begin
                    push_cpld_byte(stream[i], -1);
                end
                stream_done = 1'b1;
            end
            begin
                while (!stream_done) begin
                    bit_r = random_bits(1);
                    @(posedge clk);
                    cpld_tready_i <= bit_r[0];
                end
            end
        join
        @(posedge clk);
        cpld_tready_i <= 1'b1;
        compare_sent_bytes();
        @(posedge clk);
        cpld_tsre_i <= 1'b1;
        @(negedge clk);
        read_status(1'b0, 1'b1);
    endtask

    task automatic unmapped_access();
        logic [3:0]  regions [4];
        logic [31:0] addr;
        int          i;
        regions = '{4'h2, 4'h7, 4'h9, 4'hf};
        for (i = 0; i < 4; i++) begin
            // same word index as a RAM word that holds known data
            addr = {regions[i], 28'd0} | ram_addr(idx_list[i]);
            bus_read(addr, 32'd0, 0);
            bus_write(addr, 4'hf, random_bits(32), 0);
            bus_write(addr, 4'b0011, random_bits(32), 0);
        end
        for (i = 0; i < 4; i++) begin
            bus_read(ram_addr(idx_list[i]), ram_model[idx_list[i]], 1);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_i         = 1'b1;
        read_i        = 1'b0;
        write_i       = 1'b0;
        address_i     = '0;
        byteenable_i  = '0;
        wrdata_i      = '0;
        cpld_tready_i = 1'b1;
        cpld_tsre_i   = 1'b1;
        stream_done   = 1'b0;
        lfsr_q        = 32'h1f2c_f610;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);

        reset_state_check();
        full_word_rw();
        partial_write_merge();
        cpld_stream_order();
        fifo_backpressure();
        unmapped_access();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== source/bytes_conv.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

module bytes_conv (
    input  logic                  clk,
    input  logic                  rst_i,
    ram_port_if.slave             bus,
    output logic                  ram_en_o,
    output logic                  ram_we_o,
    output logic [`RAM_IDX_W-1:0] ram_idx_o,
    output dbus_pkg::word_t       ram_wdata_o,
    input  dbus_pkg::word_t       ram_rdata_i
);
    typedef enum logic {
        ST_IDLE,
        ST_SECOND
    } state_e;

    state_e          state_q;
    state_e          state_d;
    logic            full_word;
    logic            need_old;
    dbus_pkg::word_t merged;

    assign full_word   = &bus.byteenable;
    assign need_old    = bus.read || (bus.write && !full_word);
    assign ram_idx_o   = bus.address.word_view.idx;
    assign bus.rddata  = ram_rdata_i;

    // enabled lanes from the master, the rest from the old word
    always_comb begin
        for (int i = 0; i < `DBUS_DATA_W/8; i++) begin
            merged[8*i +: 8] = bus.byteenable[i] ? bus.wrdata[8*i +: 8]
                                                 : ram_rdata_i[8*i +: 8];
        end
    end

    always_comb begin
        state_d     = state_q;
        ram_en_o    = 1'b0;
        ram_we_o    = 1'b0;
        ram_wdata_o = bus.wrdata;
        bus.stall   = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (need_old) begin
                    ram_en_o  = 1'b1;
                    bus.stall = 1'b1;
                    state_d   = ST_SECOND;
                end else if (bus.write) begin
                    ram_en_o = 1'b1;
                    ram_we_o = 1'b1;
                end
            end
            ST_SECOND: begin
                // old word is on ram_rdata_i now
                if (bus.write) begin
                    ram_en_o    = 1'b1;
                    ram_we_o    = 1'b1;
                    ram_wdata_o = merged;
                end
                state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (rst_i)
        bus.stall |=> $stable(bus.address) && $stable(bus.byteenable)
                      && $stable(bus.wrdata) && $stable(bus.read)
                      && $stable(bus.write));

endmodule

// ==== source/cpld_pkg.sv ====
`include "dbus_macros.svh"

package cpld_pkg;

    // offsets inside the CPLD region
    typedef enum logic [7:0] {
        CPLD_DATA   = 8'h00,
        CPLD_STATUS = 8'h04
    } cpld_reg_e;

    typedef struct packed {
        logic [`DBUS_DATA_W-4:0] zero;
        logic                    tsre;
        logic                    tx_full;
        logic                    tx_empty;
    } cpld_status_s;

endpackage

// ==== source/cpld_tx.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

module cpld_tx (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       empty_i,
    output logic       pop_o,
    input  logic [7:0] data_i,
    input  logic       cpld_tready_i,
    output logic       cpld_wrn_o,
    output logic       cpld_rdn_o,
    output logic [7:0] cpld_data_o
);
    localparam int CNT_W = $clog2(`CPLD_WR_CYCLES + 1);

    typedef enum logic {
        ST_IDLE,
        ST_STROBE
    } state_e;

    state_e           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic [7:0]       data_q;

    // idle doubles as the recovery cycle, wrn is high there
    assign pop_o       = (state_q == ST_IDLE) && !empty_i && cpld_tready_i;
    assign cpld_data_o = data_q;
    assign cpld_rdn_o  = 1'b1;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            cnt_q      <= '0;
            cpld_wrn_o <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (pop_o) begin
                        cpld_wrn_o <= 1'b0;
                        cnt_q      <= CNT_W'(`CPLD_WR_CYCLES - 1);
                        state_q    <= ST_STROBE;
                    end
                end
                ST_STROBE: begin
                    if (cnt_q == '0) begin
                        cpld_wrn_o <= 1'b1;
                        state_q    <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            data_q <= data_i;
        end
    end

    a_data_hold: assert property (@(posedge clk) disable iff (rst_i)
        !cpld_wrn_o |=> cpld_wrn_o || $stable(cpld_data_o));

endmodule

// ==== source/dbus_decoder.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

module dbus_decoder (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      read_i,
    input  logic                      write_i,
    input  dbus_pkg::bus_addr_u       address_i,
    input  logic [`DBUS_DATA_W/8-1:0] byteenable_i,
    input  dbus_pkg::word_t           wrdata_i,
    output dbus_pkg::word_t           rddata_o,
    output logic                      stall_o,
    ram_port_if.master                ram,
    output logic                      push_o,
    output logic [7:0]                push_data_o,
    input  logic                      fifo_full_i,
    input  logic                      fifo_empty_i,
    input  logic                      cpld_tsre_i
);
    logic                   sel_ram;
    logic                   sel_cpld;
    logic [7:0]             reg_off;
    logic                   is_data;
    logic                   is_status;
    logic                   data_wr;
    logic                   tsre_q;
    cpld_pkg::cpld_status_s status;

    always_comb begin
        sel_ram  = 1'b0;
        sel_cpld = 1'b0;
        case (address_i.region_view.region)
            dbus_pkg::REGION_RAM:  sel_ram  = 1'b1;
            dbus_pkg::REGION_CPLD: sel_cpld = 1'b1;
            default: ;
        endcase
    end

    // upper offset bits alias onto the two registers
    assign reg_off   = address_i.region_view.offset[7:0];
    assign is_data   = sel_cpld && (reg_off == cpld_pkg::CPLD_DATA);
    assign is_status = sel_cpld && (reg_off == cpld_pkg::CPLD_STATUS);
    assign data_wr   = write_i && is_data;

    assign ram.address    = address_i;
    assign ram.byteenable = byteenable_i;
    assign ram.read       = read_i && sel_ram;
    assign ram.write      = write_i && sel_ram;
    assign ram.wrdata     = wrdata_i;

    assign push_o      = data_wr && !fifo_full_i;
    assign push_data_o = wrdata_i[7:0];

    // tsre comes straight off the CPLD pin
    always_ff @(posedge clk) begin
        if (rst_i) begin
            tsre_q <= 1'b0;
        end else begin
            tsre_q <= cpld_tsre_i;
        end
    end

    always_comb begin
        status          = '0;
        status.tsre     = tsre_q;
        status.tx_full  = fifo_full_i;
        status.tx_empty = fifo_empty_i;
    end

    always_comb begin
        rddata_o = '0;
        if (sel_ram) begin
            rddata_o = ram.rddata;
        end else if (is_status) begin
            rddata_o = status;
        end
    end

    // full FIFO holds the data write until a slot frees
    assign stall_o = (sel_ram && ram.stall) || (data_wr && fifo_full_i);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst_i)
        !(read_i && write_i));

endmodule

// ==== source/dbus_pkg.sv ====
`include "dbus_macros.svh"

package dbus_pkg;

    typedef logic [`DBUS_DATA_W-1:0] word_t;

    // anything else in the region field is unmapped
    typedef enum logic [3:0] {
        REGION_RAM  = 4'd0,
        REGION_CPLD = 4'd1
    } region_e;

    typedef struct packed {
        logic [3:0]              region;
        logic [`DBUS_ADDR_W-5:0] offset;
    } addr_region_s;

    // byte address, lane bits below the word index
    typedef struct packed {
        logic [`DBUS_ADDR_W-`RAM_IDX_W-3:0] unused;
        logic [`RAM_IDX_W-1:0]              idx;
        logic [1:0]                         lane;
    } addr_word_s;

    typedef union packed {
        addr_region_s region_view;
        addr_word_s   word_view;
    } bus_addr_u;

endpackage

// ==== source/dbus_subsys_top.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

module dbus_subsys_top (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      read_i,
    input  logic                      write_i,
    input  logic [`DBUS_ADDR_W-1:0]   address_i,
    input  logic [`DBUS_DATA_W/8-1:0] byteenable_i,
    input  logic [`DBUS_DATA_W-1:0]   wrdata_i,
    output logic [`DBUS_DATA_W-1:0]   rddata_o,
    output logic                      stall_o,
    input  logic                      cpld_tready_i,
    input  logic                      cpld_tsre_i,
    output logic                      cpld_wrn_o,
    output logic                      cpld_rdn_o,
    output logic [7:0]                cpld_data_o
);
    logic                  ram_en;
    logic                  ram_we;
    logic [`RAM_IDX_W-1:0] ram_idx;
    dbus_pkg::word_t       ram_wdata;
    dbus_pkg::word_t       ram_rdata;
    logic                  push;
    logic [7:0]            push_data;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic                  pop;
    logic [7:0]            pop_data;

    ram_port_if ram_bus ();

    dbus_decoder dbus0 (
        .clk          (clk),
        .rst_i        (rst_i),
        .read_i       (read_i),
        .write_i      (write_i),
        .address_i    (address_i),
        .byteenable_i (byteenable_i),
        .wrdata_i     (wrdata_i),
        .rddata_o     (rddata_o),
        .stall_o      (stall_o),
        .ram          (ram_bus),
        .push_o       (push),
        .push_data_o  (push_data),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .cpld_tsre_i  (cpld_tsre_i)
    );

    bytes_conv mem_conv (
        .clk         (clk),
        .rst_i       (rst_i),
        .bus         (ram_bus),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_idx_o   (ram_idx),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    word_ram ram0 (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .idx_i   (ram_idx),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    tx_fifo #(
        .DEPTH (`TX_FIFO_DEPTH)
    ) tx_fifo0 (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    cpld_tx cpld_tx0 (
        .clk           (clk),
        .rst_i         (rst_i),
        .empty_i       (fifo_empty),
        .pop_o         (pop),
        .data_i        (pop_data),
        .cpld_tready_i (cpld_tready_i),
        .cpld_wrn_o    (cpld_wrn_o),
        .cpld_rdn_o    (cpld_rdn_o),
        .cpld_data_o   (cpld_data_o)
    );

endmodule

// ==== source/ram_port_if.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

// request stays put until a cycle with stall low
interface ram_port_if;
    dbus_pkg::bus_addr_u       address;
    logic [`DBUS_DATA_W/8-1:0] byteenable;
    logic                      read;
    logic                      write;
    dbus_pkg::word_t           wrdata;
    dbus_pkg::word_t           rddata;
    logic                      stall;

    modport master (
        output address, byteenable, read, write, wrdata,
        input  rddata, stall
    );

    modport slave (
        input  address, byteenable, read, write, wrdata,
        output rddata, stall
    );
endinterface

// ==== source/tx_fifo.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

module tx_fifo #(
    parameter int DEPTH = `TX_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst_i,
    input  logic       push_i,
    input  logic [7:0] push_data_i,
    input  logic       pop_i,
    output logic [7:0] pop_data_o,
    output logic       full_o,
    output logic       empty_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // head byte is visible before the pop
    assign pop_data_o = mem[rd_ptr];
    assign full_o     = (count == CNT_W'(DEPTH));
    assign empty_o    = (count == '0);

    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst_i)
        pop_i |-> !empty_o);

endmodule

// ==== source/word_ram.sv ====
`timescale 1ns/1ps
`include "dbus_macros.svh"

module word_ram (
    input  logic                  clk,
    input  logic                  en_i,
    input  logic                  we_i,
    input  logic [`RAM_IDX_W-1:0] idx_i,
    input  dbus_pkg::word_t       wdata_i,
    output dbus_pkg::word_t       rdata_o
);
    dbus_pkg::word_t mem [`RAM_WORDS];

    // read returns the word as it was before a write in the same cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[idx_i] <= wdata_i;
            end
            rdata_o <= mem[idx_i];
        end
    end

endmodule

// ==== sources.f ====
+incdir+include
source/dbus_pkg.sv
source/cpld_pkg.sv
source/ram_port_if.sv
source/word_ram.sv
source/tx_fifo.sv
source/cpld_tx.sv
source/bytes_conv.sv
source/dbus_decoder.sv
source/dbus_subsys_top.sv
sim/tb_dbus_subsys.sv
